//--- rtl/hub_pkg.sv
`default_nettype none

package hub_pkg;

    // link counts and field widths
    localparam int DOWNSTREAM_COUNT = 2;
    localparam int FPGA_ID_WIDTH = 4;
    localparam int FIFO_ID_WIDTH = 2;
    localparam int MSG_WIDTH = 24;
    localparam int PAYLOAD_WIDTH = MSG_WIDTH - FPGA_ID_WIDTH - FIFO_ID_WIDTH;

    // physical flit widths, 2 flits upstream and 3 flits downstream per message
    localparam int UP_FLIT_WIDTH = 12;
    localparam int DOWN_FLIT_WIDTH = 8;

    // flit counter sized for the narrowest flit
    localparam int FLIT_CNT_WIDTH = $clog2(MSG_WIDTH / DOWN_FLIT_WIDTH);

    localparam int LINK_FIFO_DEPTH = 16;

    typedef struct packed {
        logic [FPGA_ID_WIDTH-1:0] dest_fpga_id;
        logic [FIFO_ID_WIDTH-1:0] fifo_id;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } hub_msg_t;

    typedef logic [UP_FLIT_WIDTH-1:0] up_flit_t;
    typedef logic [DOWN_FLIT_WIDTH-1:0] down_flit_t;

    // one bit per output link, top bit is upstream
    typedef logic [DOWNSTREAM_COUNT:0] dest_mask_t;

    // fifo id reserved for the stage controller
    localparam logic [FIFO_ID_WIDTH-1:0] STAGE_CONTROLLER_ID = '1;

    // inclusive fpga id range served by each downstream port
    localparam logic [DOWNSTREAM_COUNT-1:0][FPGA_ID_WIDTH-1:0] ROUTE_LOW = {
        4'd4,
        4'd1
    };
    localparam logic [DOWNSTREAM_COUNT-1:0][FPGA_ID_WIDTH-1:0] ROUTE_HIGH = {
        4'd6,
        4'd3
    };

endpackage

`default_nettype wire

//--- rtl/link_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module link_fifo #(
    parameter type flit_t = logic [7:0],
    parameter int DEPTH = 16
) (
    input wire clk,
    input wire reset,
    input wire flit_t in_data,
    input wire in_valid,
    output logic in_ready,
    output flit_t out_data,
    output logic out_valid,
    input wire out_ready
);

    flit_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic do_write;
    logic do_read;

    assign in_ready = (count != $bits(count)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/flit_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module flit_deserializer import hub_pkg::*; #(
    parameter type flit_t = logic [7:0]
) (
    input wire clk,
    input wire reset,
    input wire flit_t flit_data,
    input wire flit_valid,
    output logic flit_ready,
    output hub_msg_t msg,
    output logic msg_valid,
    input wire msg_taken
);

    logic [MSG_WIDTH-1:0] msg_reg;
    logic [FLIT_CNT_WIDTH-1:0] flit_cnt;
    logic flit_accept;
    logic last_flit;

    // stall the link while a whole message waits for the arbiter
    assign flit_ready = !msg_valid;
    assign flit_accept = flit_valid && flit_ready;
    assign last_flit = (flit_cnt == FLIT_CNT_WIDTH'(MSG_WIDTH / $bits(flit_t) - 1));

    assign msg = hub_msg_t'(msg_reg);

    // first flit ends up in the top bits
    always_ff @(posedge clk) begin
        if (flit_accept) begin
            msg_reg <= {msg_reg[MSG_WIDTH-$bits(flit_t)-1:0], flit_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flit_cnt <= '0;
            msg_valid <= 1'b0;
        end else begin
            if (flit_accept) begin
                if (last_flit) begin
                    flit_cnt <= '0;
                    msg_valid <= 1'b1;
                end else begin
                    flit_cnt <= flit_cnt + FLIT_CNT_WIDTH'(1);
                end
            end else if (msg_taken) begin
                msg_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/flit_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module flit_serializer import hub_pkg::*; #(
    parameter type flit_t = logic [7:0]
) (
    input wire clk,
    input wire reset,
    input wire hub_msg_t msg,
    input wire msg_valid,
    output logic msg_ready,
    output flit_t flit_data,
    output logic flit_valid,
    input wire flit_ready
);

    logic [MSG_WIDTH-1:0] shift_reg;
    logic [FLIT_CNT_WIDTH-1:0] flit_cnt;
    logic msg_accept;
    logic flit_sent;
    logic last_flit;

    // idle whenever no flit is pending on the link
    assign msg_ready = !flit_valid;
    assign msg_accept = msg_valid && msg_ready;
    assign flit_sent = flit_valid && flit_ready;
    assign last_flit = (flit_cnt == FLIT_CNT_WIDTH'(MSG_WIDTH / $bits(flit_t) - 1));

    // most significant flit goes first
    assign flit_data = flit_t'(shift_reg[MSG_WIDTH-1 -: $bits(flit_t)]);

    always_ff @(posedge clk) begin
        if (msg_accept) begin
            shift_reg <= msg;
        end else if (flit_sent) begin
            shift_reg <= shift_reg << $bits(flit_t);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flit_valid <= 1'b0;
            flit_cnt <= '0;
        end else if (msg_accept) begin
            flit_valid <= 1'b1;
            flit_cnt <= '0;
        end else if (flit_sent) begin
            if (last_flit) begin
                flit_valid <= 1'b0;
                flit_cnt <= '0;
            end else begin
                flit_cnt <= flit_cnt + FLIT_CNT_WIDTH'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/message_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module message_arbiter import hub_pkg::*; (
    input wire clk,
    input wire reset,
    input wire hub_msg_t up_msg,
    input wire up_valid,
    input wire hub_msg_t [DOWNSTREAM_COUNT-1:0] down_msg,
    input wire [DOWNSTREAM_COUNT-1:0] down_valid,
    input wire route_ready,
    output logic up_taken,
    output logic [DOWNSTREAM_COUNT-1:0] down_taken,
    output hub_msg_t sel_msg,
    output logic sel_valid,
    output logic sel_from_up
);

    logic [DOWNSTREAM_COUNT-1:0] down_grant;
    hub_msg_t down_pick_msg;

    // isolate the lowest set valid bit
    assign down_grant = down_valid & (~down_valid + DOWNSTREAM_COUNT'(1));

    always_comb begin
        down_pick_msg = '0;
        for (int i = 0; i < DOWNSTREAM_COUNT; i++) begin
            if (down_grant[i]) begin
                down_pick_msg = down_msg[i];
            end
        end
    end

    // upstream wins over every downstream link
    assign up_taken = route_ready && up_valid;
    assign down_taken = (route_ready && !up_valid) ? down_grant : '0;

    always_ff @(posedge clk) begin
        if (route_ready) begin
            sel_msg <= up_valid ? up_msg : down_pick_msg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_valid <= 1'b0;
            sel_from_up <= 1'b0;
        end else if (route_ready) begin
            // nothing offered clears the selection
            sel_valid <= up_valid || (|down_valid);
            sel_from_up <= up_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/route_stage.sv
`timescale 1ns/1ps
`default_nettype none

module route_stage import hub_pkg::*; (
    input wire clk,
    input wire reset,
    input wire hub_msg_t sel_msg,
    input wire sel_valid,
    input wire sel_from_up,
    input wire dest_mask_t ser_ready,
    output logic route_ready,
    output hub_msg_t out_msg,
    output dest_mask_t out_issue
);

    dest_mask_t table_mask;
    dest_mask_t route_mask;
    logic is_stage_ctrl;

    // every serializer must be idle so a broadcast leaves in one cycle
    assign route_ready = &ser_ready;

    assign is_stage_ctrl = (sel_msg.fifo_id == STAGE_CONTROLLER_ID);

    // range lookup, unmatched ids go upstream
    always_comb begin
        table_mask = '0;
        for (int i = 0; i < DOWNSTREAM_COUNT; i++) begin
            table_mask[i] = (sel_msg.dest_fpga_id >= ROUTE_LOW[i])
                && (sel_msg.dest_fpga_id <= ROUTE_HIGH[i]);
        end
        table_mask[DOWNSTREAM_COUNT] = ~|table_mask[DOWNSTREAM_COUNT-1:0];
    end

    always_comb begin
        if (is_stage_ctrl && sel_from_up) begin
            // broadcast down the tree
            route_mask = {1'b0, {DOWNSTREAM_COUNT{1'b1}}};
        end else if (is_stage_ctrl) begin
            // report back toward the root
            route_mask = {1'b1, {DOWNSTREAM_COUNT{1'b0}}};
        end else begin
            route_mask = table_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (route_ready) begin
            out_msg <= sel_msg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_issue <= '0;
        end else if (route_ready) begin
            out_issue <= sel_valid ? route_mask : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cluster_hub.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_hub import hub_pkg::*; (
    input wire clk,
    input wire reset,

    input wire up_flit_t upstream_in_data,
    input wire upstream_in_valid,
    output wire upstream_in_ready,
    output wire up_flit_t upstream_out_data,
    output wire upstream_out_valid,
    input wire upstream_out_ready,

    input wire down_flit_t [DOWNSTREAM_COUNT-1:0] downstream_in_data,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_in_valid,
    output wire [DOWNSTREAM_COUNT-1:0] downstream_in_ready,
    output wire down_flit_t [DOWNSTREAM_COUNT-1:0] downstream_out_data,
    output wire [DOWNSTREAM_COUNT-1:0] downstream_out_valid,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_out_ready,

    input wire [DOWNSTREAM_COUNT-1:0] downstream_has_message_flying,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_has_odd_clusters,
    output logic upstream_has_message_flying,
    output logic upstream_has_odd_clusters
);

    wire up_flit_t up_fifo_data;
    wire up_fifo_valid;
    wire up_fifo_ready;
    wire hub_msg_t up_msg;
    wire up_msg_valid;
    wire up_msg_taken;

    wire hub_msg_t [DOWNSTREAM_COUNT-1:0] down_msg;
    wire [DOWNSTREAM_COUNT-1:0] down_msg_valid;
    wire [DOWNSTREAM_COUNT-1:0] down_msg_taken;

    wire hub_msg_t sel_msg;
    wire sel_valid;
    wire sel_from_up;
    wire route_ready;
    wire hub_msg_t out_msg;
    wire dest_mask_t out_issue;
    wire dest_mask_t ser_ready;

    // status toward the parent FPGA
    always_ff @(posedge clk) begin
        if (reset) begin
            upstream_has_odd_clusters <= 1'b0;
            upstream_has_message_flying <= 1'b0;
        end else begin
            upstream_has_odd_clusters <= |downstream_has_odd_clusters;
            upstream_has_message_flying <= (|downstream_has_message_flying)
                || upstream_in_valid || upstream_out_valid
                || (|downstream_in_valid) || (|downstream_out_valid);
        end
    end

    // upstream input path
    link_fifo #(.flit_t(up_flit_t), .DEPTH(LINK_FIFO_DEPTH)) i_up_fifo (
        .clk(clk),
        .reset(reset),
        .in_data(upstream_in_data),
        .in_valid(upstream_in_valid),
        .in_ready(upstream_in_ready),
        .out_data(up_fifo_data),
        .out_valid(up_fifo_valid),
        .out_ready(up_fifo_ready)
    );

    flit_deserializer #(.flit_t(up_flit_t)) i_up_deser (
        .clk(clk),
        .reset(reset),
        .flit_data(up_fifo_data),
        .flit_valid(up_fifo_valid),
        .flit_ready(up_fifo_ready),
        .msg(up_msg),
        .msg_valid(up_msg_valid),
        .msg_taken(up_msg_taken)
    );

    for (genvar i = 0; i < DOWNSTREAM_COUNT; i++) begin : g_down_in
        wire down_flit_t fifo_data;
        wire fifo_valid;
        wire fifo_ready;

        link_fifo #(.flit_t(down_flit_t), .DEPTH(LINK_FIFO_DEPTH)) i_fifo (
            .clk(clk),
            .reset(reset),
            .in_data(downstream_in_data[i]),
            .in_valid(downstream_in_valid[i]),
            .in_ready(downstream_in_ready[i]),
            .out_data(fifo_data),
            .out_valid(fifo_valid),
            .out_ready(fifo_ready)
        );

        flit_deserializer #(.flit_t(down_flit_t)) i_deser (
            .clk(clk),
            .reset(reset),
            .flit_data(fifo_data),
            .flit_valid(fifo_valid),
            .flit_ready(fifo_ready),
            .msg(down_msg[i]),
            .msg_valid(down_msg_valid[i]),
            .msg_taken(down_msg_taken[i])
        );
    end

    message_arbiter i_arbiter (
        .clk(clk),
        .reset(reset),
        .up_msg(up_msg),
        .up_valid(up_msg_valid),
        .down_msg(down_msg),
        .down_valid(down_msg_valid),
        .route_ready(route_ready),
        .up_taken(up_msg_taken),
        .down_taken(down_msg_taken),
        .sel_msg(sel_msg),
        .sel_valid(sel_valid),
        .sel_from_up(sel_from_up)
    );

    route_stage i_route (
        .clk(clk),
        .reset(reset),
        .sel_msg(sel_msg),
        .sel_valid(sel_valid),
        .sel_from_up(sel_from_up),
        .ser_ready(ser_ready),
        .route_ready(route_ready),
        .out_msg(out_msg),
        .out_issue(out_issue)
    );

    // output paths, issued together when every serializer is idle
    for (genvar i = 0; i < DOWNSTREAM_COUNT; i++) begin : g_down_out
        flit_serializer #(.flit_t(down_flit_t)) i_ser (
            .clk(clk),
            .reset(reset),
            .msg(out_msg),
            .msg_valid(out_issue[i] && route_ready),
            .msg_ready(ser_ready[i]),
            .flit_data(downstream_out_data[i]),
            .flit_valid(downstream_out_valid[i]),
            .flit_ready(downstream_out_ready[i])
        );
    end

    flit_serializer #(.flit_t(up_flit_t)) i_up_ser (
        .clk(clk),
        .reset(reset),
        .msg(out_msg),
        .msg_valid(out_issue[DOWNSTREAM_COUNT] && route_ready),
        .msg_ready(ser_ready[DOWNSTREAM_COUNT]),
        .flit_data(upstream_out_data),
        .flit_valid(upstream_out_valid),
        .flit_ready(upstream_out_ready)
    );

endmodule

`default_nettype wire

//--- test/cluster_hub_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_hub_assertions import hub_pkg::*; (
    input wire clk,
    input wire reset,
    input wire upstream_in_valid,
    input wire upstream_in_ready,
    input wire up_flit_t upstream_out_data,
    input wire upstream_out_valid,
    input wire upstream_out_ready,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_in_valid,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_in_ready,
    input wire down_flit_t [DOWNSTREAM_COUNT-1:0] downstream_out_data,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_out_valid,
    input wire [DOWNSTREAM_COUNT-1:0] downstream_out_ready
);

    // pending output flit stays put until the link takes it
    assert property (@(posedge clk) disable iff (reset)
        upstream_out_valid && !upstream_out_ready
        |=> upstream_out_valid && $stable(upstream_out_data))
        else $error("upstream output dropped or changed a pending flit");

    // outputs quiet while reset is held
    assert property (@(posedge clk)
        reset |=> !upstream_out_valid && (downstream_out_valid == '0))
        else $error("an output valid was high during reset");

    // in ready drops only when an accepted flit fills the last free entry
    assert property (@(posedge clk) disable iff (reset)
        $fell(upstream_in_ready) |-> $past(upstream_in_valid))
        else $error("upstream in ready fell without an accepted flit");

    for (genvar i = 0; i < DOWNSTREAM_COUNT; i++) begin : g_down
        assert property (@(posedge clk) disable iff (reset)
            downstream_out_valid[i] && !downstream_out_ready[i]
            |=> downstream_out_valid[i] && $stable(downstream_out_data[i]))
            else $error("downstream output %0d dropped or changed a pending flit", i);

        assert property (@(posedge clk) disable iff (reset)
            $fell(downstream_in_ready[i]) |-> $past(downstream_in_valid[i]))
            else $error("downstream input %0d in ready fell without an accepted flit", i);
    end

endmodule

bind cluster_hub cluster_hub_assertions i_assertions (.*);

`default_nettype wire

//--- test/tb_cluster_hub.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_hub import hub_pkg::*; ();

    // link index DOWNSTREAM_COUNT is the upstream link, as in dest_mask_t
    localparam int NUM_LINKS = DOWNSTREAM_COUNT + 1;
    localparam int UP = DOWNSTREAM_COUNT;
    localparam int UP_FLITS = MSG_WIDTH / UP_FLIT_WIDTH;
    localparam int DOWN_FLITS = MSG_WIDTH / DOWN_FLIT_WIDTH;
    localparam int FLIT_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 100000;

    logic clk = 1'b0;
    logic reset = 1'b1;
    up_flit_t upstream_in_data = '0;
    logic upstream_in_valid = 1'b0;
    logic upstream_in_ready;
    up_flit_t upstream_out_data;
    logic upstream_out_valid;
    logic upstream_out_ready = 1'b0;
    down_flit_t [DOWNSTREAM_COUNT-1:0] downstream_in_data = '0;
    logic [DOWNSTREAM_COUNT-1:0] downstream_in_valid = '0;
    logic [DOWNSTREAM_COUNT-1:0] downstream_in_ready;
    down_flit_t [DOWNSTREAM_COUNT-1:0] downstream_out_data;
    logic [DOWNSTREAM_COUNT-1:0] downstream_out_valid;
    logic [DOWNSTREAM_COUNT-1:0] downstream_out_ready = '0;
    logic [DOWNSTREAM_COUNT-1:0] downstream_has_message_flying = '0;
    logic [DOWNSTREAM_COUNT-1:0] downstream_has_odd_clusters = '0;
    logic upstream_has_message_flying;
    logic upstream_has_odd_clusters;

    integer seed = 32'h540ee6dc;
    string test_name = "reset";
    int ready_pct = 50;
    int active_senders = 0;
    // expected messages, indexed by source * NUM_LINKS + destination
    hub_msg_t exp_q [NUM_LINKS*NUM_LINKS][$];
    logic [MSG_WIDTH-1:0] rx_shift [NUM_LINKS];
    int rx_count [NUM_LINKS] = '{default: 0};

    cluster_hub i_cluster_hub (.*);

    always #5 clk = ~clk;

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_msg(string what, hub_msg_t expected, hub_msg_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s %s expected %h actual %h",
                test_name, what, expected, actual));
        end
    endtask

    task automatic check_flag(string what, logic expected, logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s %s expected %b actual %b",
                test_name, what, expected, actual));
        end
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // source index rides in the top payload bits so a receiver finds its queue
    function automatic hub_msg_t make_msg(int src, int ctrl_pct);
        hub_msg_t m;
        logic [31:0] rnd;
        rnd = $random(seed);
        m.dest_fpga_id = rnd[3:0];
        m.fifo_id = (rand_below(100) < ctrl_pct) ? 2'b11 : 2'(rand_below(3));
        m.payload = {2'(src), rnd[31:16]};
        return m;
    endfunction

    // routing rules and table: ids 1..3 port 0, ids 4..6 port 1, others upstream
    function automatic dest_mask_t route_model(hub_msg_t m, int src);
        dest_mask_t mask;
        mask = '0;
        if (m.fifo_id == 2'b11) begin
            if (src == UP) begin
                mask[DOWNSTREAM_COUNT-1:0] = '1;
            end else begin
                mask[UP] = 1'b1;
            end
        end else if (m.dest_fpga_id >= 4'd1 && m.dest_fpga_id <= 4'd3) begin
            mask[0] = 1'b1;
        end else if (m.dest_fpga_id >= 4'd4 && m.dest_fpga_id <= 4'd6) begin
            mask[1] = 1'b1;
        end else begin
            mask[UP] = 1'b1;
        end
        return mask;
    endfunction

    function automatic logic queues_empty();
        for (int i = 0; i < NUM_LINKS * NUM_LINKS; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic match_received(int d, hub_msg_t m);
        int src;
        src = int'(m.payload[PAYLOAD_WIDTH-1 -: 2]);
        if (src >= NUM_LINKS || exp_q[src*NUM_LINKS+d].size() == 0) begin
            report_failure($sformatf("port %0d received unexpected message %h in %s",
                d, m, test_name));
        end else begin
            check_msg($sformatf("port %0d from link %0d", d, src),
                exp_q[src*NUM_LINKS+d].pop_front(), m);
        end
    endtask

    // output link models, valid and data are stable between rising edges
    always @(negedge clk) begin
        logic ready_now;
        for (int d = 0; d < NUM_LINKS; d++) begin
            ready_now = rand_below(100) < ready_pct;
            if (d == UP) begin
                upstream_out_ready = ready_now;
                if (upstream_out_valid && ready_now) begin
                    rx_shift[d] = {rx_shift[d][MSG_WIDTH-UP_FLIT_WIDTH-1:0], upstream_out_data};
                    rx_count[d]++;
                end
            end else begin
                downstream_out_ready[d] = ready_now;
                if (downstream_out_valid[d] && ready_now) begin
                    rx_shift[d] = {rx_shift[d][MSG_WIDTH-DOWN_FLIT_WIDTH-1:0],
                        downstream_out_data[d]};
                    rx_count[d]++;
                end
            end
            if (rx_count[d] == ((d == UP) ? UP_FLITS : DOWN_FLITS)) begin
                rx_count[d] = 0;
                match_received(d, hub_msg_t'(rx_shift[d]));
            end
        end
    end

    task automatic drive_in_valid(int src, logic value);
        if (src == UP) begin
            upstream_in_valid = value;
        end else begin
            downstream_in_valid[src] = value;
        end
    endtask

    // first flit carries the top bits
    task automatic send_msg(int src, hub_msg_t m);
        logic [MSG_WIDTH-1:0] bits;
        int flits;
        int wait_cycles;
        bits = m;
        flits = (src == UP) ? UP_FLITS : DOWN_FLITS;
        for (int f = 0; f < flits; f++) begin
            @(negedge clk);
            if (src == UP) begin
                upstream_in_data = bits[MSG_WIDTH-1-f*UP_FLIT_WIDTH -: UP_FLIT_WIDTH];
            end else begin
                downstream_in_data[src] = bits[MSG_WIDTH-1-f*DOWN_FLIT_WIDTH -: DOWN_FLIT_WIDTH];
            end
            drive_in_valid(src, 1'b1);
            wait_cycles = 0;
            while (!((src == UP) ? upstream_in_ready : downstream_in_ready[src])) begin
                if (wait_cycles == FLIT_TIMEOUT) begin
                    report_failure($sformatf("timeout: input link %0d never became ready", src));
                end
                wait_cycles++;
                @(negedge clk);
            end
            @(posedge clk);
        end
    endtask

    task automatic send_batch(int src, int count, int ctrl_pct);
        hub_msg_t m;
        dest_mask_t mask;
        for (int k = 0; k < count; k++) begin
            m = make_msg(src, ctrl_pct);
            mask = route_model(m, src);
            for (int d = 0; d < NUM_LINKS; d++) begin
                if (mask[d]) begin
                    exp_q[src*NUM_LINKS+d].push_back(m);
                end
            end
            // occasional idle cycle between messages
            if (rand_below(4) == 0) begin
                @(negedge clk);
                drive_in_valid(src, 1'b0);
            end
            send_msg(src, m);
        end
        @(negedge clk);
        drive_in_valid(src, 1'b0);
        active_senders--;
    endtask

    task automatic run_traffic(string name, int first_src, int last_src, int count,
            int ctrl_pct, int rpct);
        int wait_cycles;
        test_name = name;
        ready_pct = rpct;
        active_senders = last_src - first_src + 1;
        for (int s = first_src; s <= last_src; s++) begin
            automatic int src = s;
            fork
                send_batch(src, count, ctrl_pct);
            join_none
        end
        wait_cycles = 0;
        while (active_senders != 0 || !queues_empty()) begin
            if (wait_cycles == DRAIN_TIMEOUT) begin
                report_failure($sformatf("timeout: messages still missing at end of %s", name));
            end
            wait_cycles++;
            @(negedge clk);
        end
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        check_flag("upstream out valid", 1'b0, upstream_out_valid);
        check_flag("upstream in ready", 1'b1, upstream_in_ready);
        for (int i = 0; i < DOWNSTREAM_COUNT; i++) begin
            check_flag($sformatf("downstream %0d out valid", i), 1'b0, downstream_out_valid[i]);
            check_flag($sformatf("downstream %0d in ready", i), 1'b1, downstream_in_ready[i]);
        end
        check_flag("message flying flag", 1'b0, upstream_has_message_flying);
        check_flag("odd clusters flag", 1'b0, upstream_has_odd_clusters);
    endtask

    // flags follow the downstream bits with one cycle of delay
    task automatic check_status_flags();
        logic [DOWNSTREAM_COUNT-1:0] fly;
        logic [DOWNSTREAM_COUNT-1:0] odd;
        logic [31:0] rnd;
        test_name = "status";
        fly = '0;
        odd = '0;
        repeat (3) @(negedge clk);
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_flag("message flying flag", |fly, upstream_has_message_flying);
            check_flag("odd clusters flag", |odd, upstream_has_odd_clusters);
            rnd = $random(seed);
            fly = rnd[DOWNSTREAM_COUNT-1:0];
            odd = rnd[DOWNSTREAM_COUNT+7:8];
            downstream_has_message_flying = fly;
            downstream_has_odd_clusters = odd;
        end
    endtask

    initial begin
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        run_traffic("routing", 0, UP, 12, 0, 60);
        run_traffic("broadcast_up", UP, UP, 8, 100, 60);
        run_traffic("controller_down", 0, DOWNSTREAM_COUNT - 1, 8, 100, 60);
        run_traffic("backpressure", 0, UP, 40, 25, 15);
        check_status_flags();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/hub_pkg.sv
rtl/link_fifo.sv
rtl/flit_deserializer.sv
rtl/flit_serializer.sv
rtl/message_arbiter.sv
rtl/route_stage.sv
rtl/cluster_hub.sv
test/cluster_hub_assertions.sv
test/tb_cluster_hub.sv

//--- Makefile
SIM := obj_dir/Vtb_cluster_hub
SOURCES := $(filter-out +%,$(shell cat sources.f))

.PHONY: run clean

$(SIM): sources.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_cluster_hub -f sources.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
